// File: list.f
verilog/mcu_pwr_pkg.sv
verilog/pwr_ctrl_if.sv
verilog/irq_vector_builder.sv
verilog/pwr_domain_seq.sv
verilog/pwr_manager.sv
verilog/mcu_pwr_top.sv
sim/tb_mcu_pwr_top.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mcu_pwr_top -f list.f > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_mcu_pwr_top > sim.log 2>&1 || true
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "no result in log"; exit 1; }

// File: sim/tb_mcu_pwr_top.sv
// testbench for the power controller top level with a power switch model per domain
// concurrent assertions check timing and values while the stimulus walks through each case

`timescale 1ns/1ps
`default_nettype none

module tb_mcu_pwr_top;

  localparam int NUM_BANKS  = 9;
  localparam int CLK_PERIOD = 10;
  localparam int BANK_T     = 3;
  localparam int CTRL_W     = 8 + 5 * NUM_BANKS;

  // cycles per test for reset, idle, irq, peripheral, cpu, retention and debug reset
  localparam int TEST_CYCLES = 3 + 10 + 42 + 30 + 35 + 25 + 6;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

  localparam mcu_pwr_pkg::dom_idx_t PERIPH_IDX = mcu_pwr_pkg::dom_idx_t'(0);
  localparam mcu_pwr_pkg::dom_idx_t BANK_IDX   = mcu_pwr_pkg::dom_idx_t'(BANK_T + 1);

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  debug_reset_n_i;
  logic                  core_sleep_i;
  logic [3:0]            timer_irq_i;
  logic                  software_irq_i;
  logic                  external_irq_i;
  logic [7:0]            gpio_ao_irq_i;
  logic                  spi_flash_irq_i;
  logic                  spi_irq_i;
  logic                  dma_done_irq_i;
  logic [31:0]           irq_mask_i;
  logic                  cmd_valid_i;
  mcu_pwr_pkg::pwr_op_e  cmd_op_i;
  mcu_pwr_pkg::dom_idx_t cmd_domain_i;
  logic [31:0]           irq_o;
  logic                  cpu_pwrgate_n_o;
  logic                  cpu_iso_n_o;
  logic                  cpu_rst_n_o;
  logic                  cpu_clkgate_n_o;
  logic                  periph_pwrgate_n_o;
  logic                  periph_iso_n_o;
  logic                  periph_rst_n_o;
  logic                  periph_clkgate_n_o;
  logic [NUM_BANKS-1:0]  bank_pwrgate_n_o;
  logic [NUM_BANKS-1:0]  bank_iso_n_o;
  logic [NUM_BANKS-1:0]  bank_rst_n_o;
  logic [NUM_BANKS-1:0]  bank_clkgate_n_o;
  logic [NUM_BANKS-1:0]  bank_retentive_n_o;

  // switch model state with index 0 for cpu, 1 for peripheral and 2 up for banks
  logic [NUM_BANKS+1:0] sw_n;
  logic [NUM_BANKS+1:0] ack_n = '1;
  int unsigned          ack_cnt [NUM_BANKS+2];
  integer               seed = 15942;

  logic              quiet_phase = 1'b0;
  logic [31:0]       irq_exp_q = '0;
  logic              periph_off_q = 1'b0;
  logic              cpu_off_q = 1'b0;
  logic              periph_ack_q = 1'b1;
  logic [3:0]        periph_word;
  logic [3:0]        periph_word_q = '1;
  logic [4:0]        bank_word;
  logic [CTRL_W-1:0] ctrl_word;
  logic [NUM_BANKS+1:0] rst_word;

  logic periph_cmd;
  logic periph_is_off;
  logic periph_off_go;
  logic periph_on_go;
  logic periph_on_busy;
  logic periph_ret_cmd;
  logic periph_ack_rose;
  logic cpu_wake;
  logic cpu_is_off;
  logic cpu_sleep_go;
  logic cpu_wake_go;
  logic bank_cmd;
  logic bank_ret_go;
  logic bank_exit_go;

  mcu_pwr_top #(
    .NUM_BANKS(NUM_BANKS)
  ) i_mcu_pwr_top (
    .clk_i,
    .rst_n_i,
    .debug_reset_n_i,
    .core_sleep_i,
    .timer_irq_i,
    .software_irq_i,
    .external_irq_i,
    .gpio_ao_irq_i,
    .spi_flash_irq_i,
    .spi_irq_i,
    .dma_done_irq_i,
    .irq_mask_i,
    .cmd_valid_i,
    .cmd_op_i,
    .cmd_domain_i,
    .irq_o,
    .cpu_pwrgate_n_o,
    .cpu_pwrgate_ack_n_i   (ack_n[0]),
    .cpu_iso_n_o,
    .cpu_rst_n_o,
    .cpu_clkgate_n_o,
    .periph_pwrgate_n_o,
    .periph_pwrgate_ack_n_i(ack_n[1]),
    .periph_iso_n_o,
    .periph_rst_n_o,
    .periph_clkgate_n_o,
    .bank_pwrgate_n_o,
    .bank_pwrgate_ack_n_i  (ack_n[NUM_BANKS+1:2]),
    .bank_iso_n_o,
    .bank_rst_n_o,
    .bank_clkgate_n_o,
    .bank_retentive_n_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // expected core interrupt word built bit by bit
  function automatic logic [31:0] irq_layout(input logic [3:0] timer, input logic sw,
                                             input logic ext, input logic [7:0] gpio,
                                             input logic flash, input logic spi,
                                             input logic dma);
    logic [31:0] w;
    w = '0;
    w[3] = sw;
    w[7] = timer[0];
    w[11] = ext;
    w[16] = timer[1];
    w[17] = timer[2];
    w[18] = timer[3];
    w[19] = dma;
    w[20] = spi;
    w[21] = flash;
    w[29:22] = gpio;
    return w;
  endfunction

  task automatic stop_on_failure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("ERR at %0t: %s expected %h got %h", $time, name, exp, got);
    stop_on_failure();
  endtask

  // single-cycle command strobe that starts on a falling edge
  task automatic send_cmd(input mcu_pwr_pkg::pwr_op_e op, input mcu_pwr_pkg::dom_idx_t dom);
    cmd_valid_i = 1'b1;
    cmd_op_i = op;
    cmd_domain_i = dom;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic drive_random_sources();
    logic [31:0] rnd;
    rnd = $random(seed);
    timer_irq_i = rnd[3:0];
    software_irq_i = rnd[4];
    external_irq_i = rnd[5];
    gpio_ao_irq_i = rnd[13:6];
    spi_flash_irq_i = rnd[14];
    spi_irq_i = rnd[15];
    dma_done_irq_i = rnd[16];
  endtask

  task automatic clear_sources();
    timer_irq_i = '0;
    software_irq_i = 1'b0;
    external_irq_i = 1'b0;
    gpio_ao_irq_i = '0;
    spi_flash_irq_i = 1'b0;
    spi_irq_i = 1'b0;
    dma_done_irq_i = 1'b0;
  endtask

  // each acknowledge follows its switch 1 to 4 cycles later
  assign sw_n = {bank_pwrgate_n_o, periph_pwrgate_n_o, cpu_pwrgate_n_o};

  always @(negedge clk_i) begin
    for (int i = 0; i < NUM_BANKS + 2; i++) begin
      if (ack_n[i] == sw_n[i]) begin
        ack_cnt[i] = 0;
      end else if (ack_cnt[i] == 0) begin
        ack_cnt[i] = 1 + ($unsigned($random(seed)) % 4);
      end else if (ack_cnt[i] == 1) begin
        ack_n[i] = sw_n[i];
        ack_cnt[i] = 0;
      end else begin
        ack_cnt[i] = ack_cnt[i] - 1;
      end
    end
  end

  // reference state kept from the pins where off counts once the acknowledge is low
  always @(posedge clk_i) begin
    irq_exp_q <= irq_layout(timer_irq_i, software_irq_i, external_irq_i, gpio_ao_irq_i,
                            spi_flash_irq_i, spi_irq_i, dma_done_irq_i);
    periph_off_q <= !periph_pwrgate_n_o && !ack_n[1];
    cpu_off_q <= !cpu_pwrgate_n_o && !ack_n[0];
    periph_ack_q <= ack_n[1];
    periph_word_q <= periph_word;
  end

  assign periph_word = {periph_pwrgate_n_o, periph_iso_n_o, periph_rst_n_o, periph_clkgate_n_o};
  assign bank_word = {bank_pwrgate_n_o[BANK_T], bank_iso_n_o[BANK_T], bank_rst_n_o[BANK_T],
                      bank_clkgate_n_o[BANK_T], bank_retentive_n_o[BANK_T]};
  assign ctrl_word = {cpu_pwrgate_n_o, cpu_iso_n_o, cpu_rst_n_o, cpu_clkgate_n_o, periph_word,
                      bank_pwrgate_n_o, bank_iso_n_o, bank_rst_n_o, bank_clkgate_n_o,
                      bank_retentive_n_o};
  assign rst_word = {bank_rst_n_o, periph_rst_n_o, cpu_rst_n_o};

  assign periph_cmd      = cmd_valid_i && (cmd_domain_i == PERIPH_IDX);
  assign periph_is_off   = periph_off_q && !periph_pwrgate_n_o;
  assign periph_off_go   = periph_cmd && (cmd_op_i == mcu_pwr_pkg::PWR_OP_OFF)
                           && periph_clkgate_n_o;
  assign periph_on_go    = periph_cmd && (cmd_op_i == mcu_pwr_pkg::PWR_OP_ON) && periph_is_off;
  assign periph_on_busy  = periph_cmd && (cmd_op_i == mcu_pwr_pkg::PWR_OP_ON)
                           && !periph_pwrgate_n_o && !periph_is_off;
  assign periph_ret_cmd  = periph_cmd && (cmd_op_i == mcu_pwr_pkg::PWR_OP_RETAIN);
  assign periph_ack_rose = ack_n[1] && !periph_ack_q;
  assign cpu_wake        = |(irq_exp_q & irq_mask_i);
  assign cpu_is_off      = cpu_off_q && !cpu_pwrgate_n_o;
  assign cpu_sleep_go    = core_sleep_i && !cpu_wake && cpu_clkgate_n_o;
  assign cpu_wake_go     = cpu_wake && cpu_is_off;
  assign bank_cmd        = cmd_valid_i && (cmd_domain_i == BANK_IDX);
  assign bank_ret_go     = bank_cmd && (cmd_op_i == mcu_pwr_pkg::PWR_OP_RETAIN)
                           && bank_clkgate_n_o[BANK_T] && bank_retentive_n_o[BANK_T];
  assign bank_exit_go    = bank_cmd && (cmd_op_i == mcu_pwr_pkg::PWR_OP_ON)
                           && !bank_retentive_n_o[BANK_T];

  a_idle_ctrl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    quiet_phase |-> ctrl_word == '1)
    else report_mismatch("control outputs", 64'({CTRL_W{1'b1}}), 64'($sampled(ctrl_word)));
  a_idle_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    quiet_phase |-> irq_o == '0)
    else report_mismatch("irq_o", 64'(32'h0), 64'($sampled(irq_o)));
  a_irq_layout: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_o == irq_exp_q)
    else report_mismatch("irq_o", 64'($sampled(irq_exp_q)), 64'($sampled(irq_o)));

  // power-down steps as {pwrgate, iso, rst, clkgate}
  a_pd_clk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_off_go, 1) |-> periph_word == 4'b1110)
    else report_mismatch("periph_word", 64'(4'b1110), 64'($sampled(periph_word)));
  a_pd_iso: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_off_go, 2) |-> periph_word == 4'b1010)
    else report_mismatch("periph_word", 64'(4'b1010), 64'($sampled(periph_word)));
  a_pd_rst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_off_go, 3) |-> periph_word == 4'b1000)
    else report_mismatch("periph_word", 64'(4'b1000), 64'($sampled(periph_word)));
  a_pd_sw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_off_go, 4) |-> periph_word == 4'b0000)
    else report_mismatch("periph_word", 64'(4'b0000), 64'($sampled(periph_word)));
  a_busy_ignored: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_on_busy, 1) |-> !periph_pwrgate_n_o)
    else report_mismatch("periph_pwrgate_n_o", 64'(1'b0), 64'($sampled(periph_pwrgate_n_o)));

  // power-up follows the acknowledge
  a_pu_sw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_on_go, 1) |-> periph_word == 4'b1000)
    else report_mismatch("periph_word", 64'(4'b1000), 64'($sampled(periph_word)));
  a_pu_rst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_ack_rose, 1) |-> periph_word == 4'b1010)
    else report_mismatch("periph_word", 64'(4'b1010), 64'($sampled(periph_word)));
  a_pu_iso: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_ack_rose, 2) |-> periph_word == 4'b1110)
    else report_mismatch("periph_word", 64'(4'b1110), 64'($sampled(periph_word)));
  a_pu_clk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_ack_rose, 3) |-> periph_word == 4'b1111)
    else report_mismatch("periph_word", 64'(4'b1111), 64'($sampled(periph_word)));

  a_cpu_sleep: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(cpu_sleep_go, 1) |-> !cpu_clkgate_n_o)
    else report_mismatch("cpu_clkgate_n_o", 64'(1'b0), 64'($sampled(cpu_clkgate_n_o)));
  a_cpu_wake: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(cpu_wake_go, 1) |-> cpu_pwrgate_n_o)
    else report_mismatch("cpu_pwrgate_n_o", 64'(1'b1), 64'($sampled(cpu_pwrgate_n_o)));
  a_cpu_masked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cpu_pwrgate_n_o) |-> $past(cpu_wake, 1))
    else begin
      $display("cpu domain powered up at %0t without an enabled interrupt", $time);
      stop_on_failure();
    end

  // retention steps as {pwrgate, iso, rst, clkgate, retentive}
  a_ret_clk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(bank_ret_go, 1) |-> bank_word == 5'b11101)
    else report_mismatch("bank_word", 64'(5'b11101), 64'($sampled(bank_word)));
  a_ret_enter: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(bank_ret_go, 2) |-> bank_word == 5'b11100)
    else report_mismatch("bank_word", 64'(5'b11100), 64'($sampled(bank_word)));
  a_ret_keep: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !bank_retentive_n_o[BANK_T] |-> bank_word[4:2] == 3'b111)
    else report_mismatch("bank_word[4:2]", 64'(3'b111), 64'($sampled(bank_word[4:2])));
  a_ret_exit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(bank_exit_go, 1) |-> bank_word == 5'b11101)
    else report_mismatch("bank_word", 64'(5'b11101), 64'($sampled(bank_word)));
  a_ret_on: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(bank_exit_go, 2) |-> bank_word == 5'b11111)
    else report_mismatch("bank_word", 64'(5'b11111), 64'($sampled(bank_word)));
  a_periph_no_ret: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(periph_ret_cmd, 1) |-> periph_word == periph_word_q)
    else report_mismatch("periph_word", 64'($sampled(periph_word_q)),
                         64'($sampled(periph_word)));

  a_debug_rst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !debug_reset_n_i |-> rst_word == '0)
    else report_mismatch("reset outputs", 64'(0), 64'($sampled(rst_word)));

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    stop_on_failure();
  end

  initial begin
    rst_n_i = 1'b0;
    debug_reset_n_i = 1'b1;
    core_sleep_i = 1'b0;
    clear_sources();
    irq_mask_i = '0;
    cmd_valid_i = 1'b0;
    cmd_op_i = mcu_pwr_pkg::PWR_OP_OFF;
    cmd_domain_i = PERIPH_IDX;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // idle after reset
    quiet_phase = 1'b1;
    repeat (10) @(negedge clk_i);
    quiet_phase = 1'b0;

    // random interrupt patterns with every source masked off
    repeat (40) begin
      drive_random_sources();
      @(negedge clk_i);
    end
    clear_sources();
    repeat (2) @(negedge clk_i);

    // peripheral off where commands during the sequence are dropped
    send_cmd(mcu_pwr_pkg::PWR_OP_OFF, PERIPH_IDX);
    send_cmd(mcu_pwr_pkg::PWR_OP_ON, PERIPH_IDX);
    while (periph_pwrgate_n_o) @(negedge clk_i);
    send_cmd(mcu_pwr_pkg::PWR_OP_ON, PERIPH_IDX);
    while (!periph_is_off) @(negedge clk_i);
    send_cmd(mcu_pwr_pkg::PWR_OP_ON, PERIPH_IDX);
    while (!periph_clkgate_n_o) @(negedge clk_i);
    repeat (2) @(negedge clk_i);

    // cpu sleeps and a masked-off timer does not wake it but the external line does
    irq_mask_i = 32'h0000_0800;
    core_sleep_i = 1'b1;
    while (!cpu_is_off) @(negedge clk_i);
    timer_irq_i = 4'b0001;
    repeat (8) @(negedge clk_i);
    external_irq_i = 1'b1;
    while (!cpu_clkgate_n_o) @(negedge clk_i);
    core_sleep_i = 1'b0;
    clear_sources();
    repeat (4) @(negedge clk_i);

    // bank retention where an OFF during entry is dropped
    send_cmd(mcu_pwr_pkg::PWR_OP_RETAIN, BANK_IDX);
    send_cmd(mcu_pwr_pkg::PWR_OP_OFF, BANK_IDX);
    while (bank_retentive_n_o[BANK_T]) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    send_cmd(mcu_pwr_pkg::PWR_OP_ON, BANK_IDX);
    while (!bank_clkgate_n_o[BANK_T]) @(negedge clk_i);
    send_cmd(mcu_pwr_pkg::PWR_OP_RETAIN, PERIPH_IDX);
    repeat (4) @(negedge clk_i);

    debug_reset_n_i = 1'b0;
    repeat (3) @(negedge clk_i);
    debug_reset_n_i = 1'b1;
    repeat (3) @(negedge clk_i);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/mcu_pwr_top.sv
// top level of the power controller with every domain signal on its own pin
// instantiate with NUM_BANKS matching the number of switched memory banks

`timescale 1ns/1ps
`default_nettype none

module mcu_pwr_top #(
  parameter int NUM_BANKS = mcu_pwr_pkg::NUM_BANKS
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  debug_reset_n_i,
  input  logic                  core_sleep_i,
  input  logic [3:0]            timer_irq_i,
  input  logic                  software_irq_i,
  input  logic                  external_irq_i,
  input  logic [7:0]            gpio_ao_irq_i,
  input  logic                  spi_flash_irq_i,
  input  logic                  spi_irq_i,
  input  logic                  dma_done_irq_i,
  input  logic [31:0]           irq_mask_i,
  input  logic                  cmd_valid_i,
  input  mcu_pwr_pkg::pwr_op_e  cmd_op_i,
  input  mcu_pwr_pkg::dom_idx_t cmd_domain_i,
  output logic [31:0]           irq_o,

  output logic                  cpu_pwrgate_n_o,
  input  logic                  cpu_pwrgate_ack_n_i,
  output logic                  cpu_iso_n_o,
  output logic                  cpu_rst_n_o,
  output logic                  cpu_clkgate_n_o,

  output logic                  periph_pwrgate_n_o,
  input  logic                  periph_pwrgate_ack_n_i,
  output logic                  periph_iso_n_o,
  output logic                  periph_rst_n_o,
  output logic                  periph_clkgate_n_o,

  output logic [NUM_BANKS-1:0]  bank_pwrgate_n_o,
  input  logic [NUM_BANKS-1:0]  bank_pwrgate_ack_n_i,
  output logic [NUM_BANKS-1:0]  bank_iso_n_o,
  output logic [NUM_BANKS-1:0]  bank_rst_n_o,
  output logic [NUM_BANKS-1:0]  bank_clkgate_n_o,
  output logic [NUM_BANKS-1:0]  bank_retentive_n_o
);

  logic wake;

  pwr_ctrl_if cpu_if ();
  pwr_ctrl_if periph_if ();
  pwr_ctrl_if bank_if [NUM_BANKS] ();

  irq_vector_builder i_irq_vector_builder (
    .clk_i,
    .rst_n_i,
    .timer_irq_i,
    .software_irq_i,
    .external_irq_i,
    .gpio_ao_irq_i,
    .spi_flash_irq_i,
    .spi_irq_i,
    .dma_done_irq_i,
    .irq_mask_i,
    .irq_o,
    .wake_o(wake)
  );

  pwr_manager #(
    .NUM_BANKS(NUM_BANKS)
  ) i_pwr_manager (
    .clk_i,
    .rst_n_i,
    .debug_reset_n_i,
    .core_sleep_i,
    .wake_i     (wake),
    .cmd_valid_i,
    .cmd_op_i,
    .cmd_domain_i,
    .cpu_ctrl   (cpu_if),
    .periph_ctrl(periph_if),
    .bank_ctrl  (bank_if)
  );

  // cpu and peripheral domains have no retention pin
  assign cpu_pwrgate_n_o       = cpu_if.pwrgate_en_n;
  assign cpu_if.pwrgate_ack_n  = cpu_pwrgate_ack_n_i;
  assign cpu_iso_n_o           = cpu_if.isogate_en_n;
  assign cpu_rst_n_o           = cpu_if.rst_n;
  assign cpu_clkgate_n_o       = cpu_if.clkgate_en_n;

  assign periph_pwrgate_n_o      = periph_if.pwrgate_en_n;
  assign periph_if.pwrgate_ack_n = periph_pwrgate_ack_n_i;
  assign periph_iso_n_o          = periph_if.isogate_en_n;
  assign periph_rst_n_o          = periph_if.rst_n;
  assign periph_clkgate_n_o      = periph_if.clkgate_en_n;

  // unroll the bank bundles to one bit per bank on each pin vector
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_pins
    assign bank_pwrgate_n_o[b]     = bank_if[b].pwrgate_en_n;
    assign bank_if[b].pwrgate_ack_n = bank_pwrgate_ack_n_i[b];
    assign bank_iso_n_o[b]         = bank_if[b].isogate_en_n;
    assign bank_rst_n_o[b]         = bank_if[b].rst_n;
    assign bank_clkgate_n_o[b]     = bank_if[b].clkgate_en_n;
    assign bank_retentive_n_o[b]   = bank_if[b].retentive_en_n;
  end

endmodule

`default_nettype wire

// File: verilog/pwr_manager.sv
// turns command strobes and core sleep into per-domain power requests
// holds the sequencers of the CPU, peripheral and memory bank domains

`timescale 1ns/1ps
`default_nettype none

module pwr_manager #(
  parameter int NUM_BANKS = mcu_pwr_pkg::NUM_BANKS
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  debug_reset_n_i,
  input  logic                  core_sleep_i,
  input  logic                  wake_i,
  input  logic                  cmd_valid_i,
  input  mcu_pwr_pkg::pwr_op_e  cmd_op_i,
  input  mcu_pwr_pkg::dom_idx_t cmd_domain_i,
  pwr_ctrl_if.seq               cpu_ctrl,
  pwr_ctrl_if.seq               periph_ctrl,
  pwr_ctrl_if.seq               bank_ctrl [NUM_BANKS]
);

  logic cmd_off;
  logic cmd_on;
  logic cmd_ret;
  logic cpu_busy;

  // one entry per command index, 0 is the peripheral domain
  logic [NUM_BANKS:0] dom_sel;
  logic [NUM_BANKS:0] dom_busy;

  assign cmd_off = cmd_valid_i && (cmd_op_i == mcu_pwr_pkg::PWR_OP_OFF);
  assign cmd_on  = cmd_valid_i && (cmd_op_i == mcu_pwr_pkg::PWR_OP_ON);
  assign cmd_ret = cmd_valid_i && (cmd_op_i == mcu_pwr_pkg::PWR_OP_RETAIN);

  // indices past the last bank select nothing
  for (genvar d = 0; d <= NUM_BANKS; d++) begin : g_sel
    assign dom_sel[d] = (cmd_domain_i == mcu_pwr_pkg::dom_idx_t'(d)) && !dom_busy[d];
  end

  // cpu domain follows the core: sleep powers it down, a masked irq brings it back
  pwr_domain_seq #(
    .HAS_RETENTION(1'b0)
  ) i_cpu_seq (
    .clk_i,
    .rst_n_i,
    .debug_reset_n_i,
    .off_req_i(core_sleep_i && !wake_i && !cpu_busy),
    .on_req_i (wake_i && !cpu_busy),
    .ret_req_i(1'b0),
    .busy_o   (cpu_busy),
    .ctrl     (cpu_ctrl)
  );

  pwr_domain_seq #(
    .HAS_RETENTION(1'b0)
  ) i_periph_seq (
    .clk_i,
    .rst_n_i,
    .debug_reset_n_i,
    .off_req_i(cmd_off && dom_sel[0]),
    .on_req_i (cmd_on && dom_sel[0]),
    .ret_req_i(cmd_ret && dom_sel[0]),
    .busy_o   (dom_busy[0]),
    .ctrl     (periph_ctrl)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    pwr_domain_seq #(
      .HAS_RETENTION(1'b1)
    ) i_bank_seq (
      .clk_i,
      .rst_n_i,
      .debug_reset_n_i,
      .off_req_i(cmd_off && dom_sel[b+1]),
      .on_req_i (cmd_on && dom_sel[b+1]),
      .ret_req_i(cmd_ret && dom_sel[b+1]),
      .busy_o   (dom_busy[b+1]),
      .ctrl     (bank_ctrl[b])
    );
  end

endmodule

`default_nettype wire

// File: verilog/pwr_domain_seq.sv
// steps one power domain through clock gate, isolation, reset and switch
// power-up waits on the switch acknowledge, banks may also enter retention

`timescale 1ns/1ps
`default_nettype none

module pwr_domain_seq #(
  parameter bit HAS_RETENTION = 1'b0
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    debug_reset_n_i,
  input  logic    off_req_i,
  input  logic    on_req_i,
  input  logic    ret_req_i,
  output logic    busy_o,
  pwr_ctrl_if.seq ctrl
);

  mcu_pwr_pkg::pwr_state_e state_q;

  logic pwr_q;
  logic iso_q;
  logic rst_q;
  logic clk_q;
  logic ret_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= mcu_pwr_pkg::ST_ON;
      pwr_q   <= 1'b1;
      iso_q   <= 1'b1;
      rst_q   <= 1'b1;
      clk_q   <= 1'b1;
      ret_q   <= 1'b1;
    end else begin
      case (state_q)
        mcu_pwr_pkg::ST_ON: begin
          // power-down wins over retention
          if (off_req_i) begin
            clk_q   <= 1'b0;
            state_q <= mcu_pwr_pkg::ST_PD_ISO;
          end else if (ret_req_i && HAS_RETENTION) begin
            clk_q   <= 1'b0;
            state_q <= mcu_pwr_pkg::ST_RET_ENTER;
          end
        end
        mcu_pwr_pkg::ST_PD_ISO: begin
          iso_q   <= 1'b0;
          state_q <= mcu_pwr_pkg::ST_PD_RST;
        end
        mcu_pwr_pkg::ST_PD_RST: begin
          rst_q   <= 1'b0;
          state_q <= mcu_pwr_pkg::ST_PD_SW;
        end
        mcu_pwr_pkg::ST_PD_SW: begin
          pwr_q   <= 1'b0;
          state_q <= mcu_pwr_pkg::ST_WAIT_OFF;
        end
        mcu_pwr_pkg::ST_WAIT_OFF: begin
          if (!ctrl.pwrgate_ack_n) begin
            state_q <= mcu_pwr_pkg::ST_OFF;
          end
        end
        mcu_pwr_pkg::ST_OFF: begin
          if (on_req_i) begin
            pwr_q   <= 1'b1;
            state_q <= mcu_pwr_pkg::ST_WAIT_ON;
          end
        end
        mcu_pwr_pkg::ST_WAIT_ON: begin
          // supply is up, release reset first
          if (ctrl.pwrgate_ack_n) begin
            rst_q   <= 1'b1;
            state_q <= mcu_pwr_pkg::ST_PU_ISO;
          end
        end
        mcu_pwr_pkg::ST_PU_ISO: begin
          iso_q   <= 1'b1;
          state_q <= mcu_pwr_pkg::ST_PU_CLK;
        end
        mcu_pwr_pkg::ST_PU_CLK: begin
          clk_q   <= 1'b1;
          state_q <= mcu_pwr_pkg::ST_ON;
        end
        mcu_pwr_pkg::ST_RET_ENTER: begin
          ret_q   <= 1'b0;
          state_q <= mcu_pwr_pkg::ST_RET;
        end
        mcu_pwr_pkg::ST_RET: begin
          if (on_req_i) begin
            ret_q   <= 1'b1;
            state_q <= mcu_pwr_pkg::ST_RET_EXIT;
          end
        end
        mcu_pwr_pkg::ST_RET_EXIT: begin
          clk_q   <= 1'b1;
          state_q <= mcu_pwr_pkg::ST_ON;
        end
        default: begin
          state_q <= mcu_pwr_pkg::ST_ON;
        end
      endcase
    end
  end

  assign busy_o = !(state_q inside {mcu_pwr_pkg::ST_ON, mcu_pwr_pkg::ST_OFF,
                                    mcu_pwr_pkg::ST_RET});

  assign ctrl.pwrgate_en_n   = pwr_q;
  assign ctrl.isogate_en_n   = iso_q;
  // debug reset forces the domain into reset in any state
  assign ctrl.rst_n          = rst_q & debug_reset_n_i;
  assign ctrl.clkgate_en_n   = clk_q;
  assign ctrl.retentive_en_n = ret_q;

  // switch may only open on a domain that is already reset and isolated
  a_pwr_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(ctrl.pwrgate_en_n) |-> $past(!ctrl.rst_n && !ctrl.isogate_en_n))
    else $error("power switch opened before reset and isolation");

  a_no_ret: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !HAS_RETENTION |-> ctrl.retentive_en_n)
    else $error("retention entered on a domain without retention");

endmodule

`default_nettype wire

// File: verilog/irq_vector_builder.sv
// packs the interrupt sources into the core interrupt word and registers it
// wake is the registered word masked by irq_mask_i

`timescale 1ns/1ps
`default_nettype none

module irq_vector_builder (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [3:0]  timer_irq_i,
  input  logic        software_irq_i,
  input  logic        external_irq_i,
  input  logic [7:0]  gpio_ao_irq_i,
  input  logic        spi_flash_irq_i,
  input  logic        spi_irq_i,
  input  logic        dma_done_irq_i,
  input  logic [31:0] irq_mask_i,
  output logic [31:0] irq_o,
  output logic        wake_o
);

  // bits 31, 15:12, 10:8, 6:4 and 2:0 carry no source
  localparam logic [31:0] RSV_MASK = 32'h8000_F777;

  mcu_pwr_pkg::irq_word_u irq_d;
  mcu_pwr_pkg::irq_word_u irq_q;

  always_comb begin
    irq_d = '0;
    // fast lines, top bit unused
    irq_d.fields.fast = {
      1'b0,
      gpio_ao_irq_i,
      spi_flash_irq_i,
      spi_irq_i,
      dma_done_irq_i,
      timer_irq_i[3],
      timer_irq_i[2],
      timer_irq_i[1]
    };
    irq_d.fields.external = external_irq_i;
    irq_d.fields.timer0   = timer_irq_i[0];
    irq_d.fields.software = software_irq_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o  = irq_q.word;
  assign wake_o = |(irq_q.word & irq_mask_i);

  // field layout must leave the reserved word bits clear
  a_rsv_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (irq_o & RSV_MASK) == 32'h0)
    else $error("reserved interrupt bits set: %h", irq_o);

endmodule

`default_nettype wire

// File: verilog/pwr_ctrl_if.sv
// power control bundle of one domain, all signals active low
// the sequencer drives it through seq, the pad side answers through pins

`timescale 1ns/1ps
`default_nettype none

interface pwr_ctrl_if;

  // low means switch off, isolation on, reset on, clock gated, retention on
  logic pwrgate_en_n;
  logic isogate_en_n;
  logic rst_n;
  logic clkgate_en_n;
  logic retentive_en_n;

  // follows pwrgate_en_n once the switch has settled
  logic pwrgate_ack_n;

  modport seq (
    output pwrgate_en_n,
    output isogate_en_n,
    output rst_n,
    output clkgate_en_n,
    output retentive_en_n,
    input  pwrgate_ack_n
  );

  modport pins (
    input  pwrgate_en_n,
    input  isogate_en_n,
    input  rst_n,
    input  clkgate_en_n,
    input  retentive_en_n,
    output pwrgate_ack_n
  );

endinterface

`default_nettype wire

// File: verilog/mcu_pwr_pkg.sv
// shared definitions for the power-domain controller and the interrupt builder
// modules refer to everything here through mcu_pwr_pkg:: scoped names

`default_nettype none

package mcu_pwr_pkg;

  // memory banks with their own power switch, default for the top level
  parameter int NUM_BANKS = 9;

  // domains a command can address: the peripheral domain plus every bank
  parameter int NUM_DOMAINS_CMD = NUM_BANKS + 1;

  parameter int FAST_IRQ_W = 15;

  // 0 is the peripheral domain, k is bank k-1
  typedef logic [$clog2(NUM_DOMAINS_CMD)-1:0] dom_idx_t;

  typedef enum logic [1:0] {
    PWR_OP_OFF    = 2'd0,
    PWR_OP_ON     = 2'd1,
    PWR_OP_RETAIN = 2'd2
  } pwr_op_e;

  // stable states are ST_ON, ST_OFF and ST_RET, all others are steps
  typedef enum logic [3:0] {
    ST_ON        = 4'd0,
    ST_PD_ISO    = 4'd1,
    ST_PD_RST    = 4'd2,
    ST_PD_SW     = 4'd3,
    ST_WAIT_OFF  = 4'd4,
    ST_OFF       = 4'd5,
    ST_WAIT_ON   = 4'd6,
    ST_PU_ISO    = 4'd7,
    ST_PU_CLK    = 4'd8,
    ST_RET_ENTER = 4'd9,
    ST_RET       = 4'd10,
    ST_RET_EXIT  = 4'd11
  } pwr_state_e;

  // core interrupt word as the core sees it, MSB first
  typedef struct packed {
    logic                  rsv_31;
    logic [FAST_IRQ_W-1:0] fast;
    logic [3:0]            rsv_15_12;
    logic                  external;
    logic [2:0]            rsv_10_8;
    logic                  timer0;
    logic [2:0]            rsv_6_4;
    logic                  software;
    logic [2:0]            rsv_2_0;
  } irq_fields_t;

  typedef union packed {
    logic [31:0] word;
    irq_fields_t fields;
  } irq_word_u;

endpackage

`default_nettype wire
